//--- sim.f
+incdir+verilog
verilog/fetchPkg.sv
verilog/programCounter.sv
verilog/fetchStage.sv
verilog/branchDecode.sv
verilog/instrMemory.sv
verilog/hazardControl.sv
verilog/frontEnd.sv
tests/frontEndTb.sv

//--- Makefile
# Verilator simulation of the instruction fetch front end

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass when the log shows the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module frontEndTb -o frontEndTb
	./obj_dir/frontEndTb | tee $(LOG)
	@grep -q "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/program.hex
// One 32-bit instruction word per line in hex, first word at address 0x3000
// A line starting with @ sets the word index counted from 0x3000
24010001
24020002
10220003
24030003
24040004
24050005
14220002
24060006
24070007
18200002
24080008
24090009
1c200002
240a000a
240b000b
08000c14
240c000c
240d000d
240e000e
240f000f
0c000c18
24100010
24110011
24120012
03e00008
24130013
@45c
00000000
00000000
00000000
00000000
24160016
24170017
03e00008
24180018

//--- tests/frontEndTb.sv
/*
 * Fetch front end testbench
 * Random back-pressure and operands, a reference model of PC and F/D,
 * exception entry, eret, address errors and the termination hold
 */

`timescale 1ns/100ps
`include "fetch_defs.svh"

module frontEndTb
    import fetchPkg::*;
;

    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [31:0] HOLD_ADDR = `KTEXT_START - 32'd4;

    logic        clk;
    logic        reset;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic        decodeStall;
    excCtrl_t    excCtrl;
    logic [29:0] epc;
    logic [31:0] pcF;
    logic        bdF;
    logic [4:0]  excF;
    instrWord_t  codeD;
    logic [31:0] pcD;
    logic        bdD;
    logic [4:0]  excD;
    logic        busy;

    logic [31:0] romImage [0:`IM_WORDS-1];
    integer      seed;
    logic        modelValid;
    logic [31:0] expPc;
    logic [31:0] expCode;
    logic [31:0] expPcD;
    logic        expBdD;
    logic [4:0]  expExcD;
    logic        modelLineValid;
    logic [27:0] modelLineTag;
    logic [27:0] pendingTag;
    int          pendingCycles;

    frontEnd dut0 (
        .clk(clk), .reset(reset),
        .rsValue(rsValue), .rtValue(rtValue),
        .decodeStall(decodeStall), .excCtrl(excCtrl), .epc(epc),
        .pcF(pcF), .bdF(bdF), .excF(excF),
        .codeD(codeD), .pcD(pcD), .bdD(bdD), .excD(excD),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportFailure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] romWord(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `IM_ADDR_START;
        if (addr < `IM_ADDR_START || addr >= `IM_ADDR_END) return 32'd0;
        return romImage[off[12:2]];
    endfunction

    function automatic logic [4:0] adelCode(input logic [31:0] addr);
        if (addr < `IM_ADDR_START || addr >= `IM_ADDR_END || addr[1:0] != 2'b00) begin
            return `EXC_ADEL;
        end
        return 5'd0;
    endfunction

    function automatic logic isJumpRegister(input logic [31:0] word);
        return word[31:26] == 6'h00 && (word[5:0] == 6'h08 || word[5:0] == 6'h09);
    endfunction

    // Any branch or jump makes the next fetch a delay slot
    function automatic logic isControlTransfer(input logic [31:0] word);
        return isJumpRegister(word) || (word[31:26] >= 6'h02 && word[31:26] <= 6'h07);
    endfunction

    function automatic logic [31:0] nextPcFromD(input logic [31:0] word, input logic [31:0] pc,
                                                input logic [31:0] pcOfD,
                                                input logic [31:0] rs, input logic [31:0] rt);
        logic [31:0] slotPc;
        logic [31:0] brTarget;
        slotPc = pcOfD + 32'd4;
        brTarget = slotPc + {{14{word[15]}}, word[15:0], 2'b00};
        if (isJumpRegister(word)) return rs;
        case (word[31:26])
            6'h02, 6'h03: return {slotPc[31:28], word[25:0], 2'b00};
            6'h04: if (rs == rt) return brTarget;
            6'h05: if (rs != rt) return brTarget;
            6'h06: if ($signed(rs) <= 0) return brTarget;
            6'h07: if ($signed(rs) > 0) return brTarget;
            default: ;
        endcase
        return pc + 32'd4;
    endfunction

    // Compare at the falling edge and predict what the next rising edge loads
    always @(negedge clk) begin : referenceModel
        logic        excReq;
        logic        stallNow;
        logic        expBusy;
        logic [27:0] lineNow;
        logic [31:0] nextPc;
        lineNow = expPc[31:4];
        expBusy = !(modelLineValid && modelLineTag == lineNow);
        if (modelValid) begin
            assert (pcF == expPc) else reportMismatch("pcF", pcF, expPc);
            assert (codeD == expCode) else reportMismatch("codeD", codeD, expCode);
            assert (pcD == expPcD) else reportMismatch("pcD", pcD, expPcD);
            assert (bdD == expBdD) else reportMismatch("bdD", 32'(bdD), 32'(expBdD));
            assert (excD == expExcD) else reportMismatch("excD", 32'(excD), 32'(expExcD));
            assert (excF == adelCode(expPc))
                else reportMismatch("excF", 32'(excF), 32'(adelCode(expPc)));
            assert (bdF == isControlTransfer(expCode))
                else reportMismatch("bdF", 32'(bdF), 32'(isControlTransfer(expCode)));
            assert (busy == expBusy) else reportMismatch("busy", 32'(busy), 32'(expBusy));
        end
        excReq = (excCtrl != excNone);
        stallNow = expBusy || decodeStall;
        if (reset) begin
            expPc = `PC_BOOT;
            expCode = 32'd0;
            expPcD = 32'd0;
            expBdD = 1'b0;
            expExcD = 5'd0;
            modelLineValid = 1'b0;
            pendingCycles = 0;
            modelValid = 1'b1;
        end else if (modelValid) begin
            // A miss fills the line after a fixed number of cycles on the same line
            if (!expBusy) begin
                pendingCycles = 0;
            end else begin
                if (pendingTag != lineNow) pendingCycles = 0;
                pendingTag = lineNow;
                pendingCycles++;
                if (pendingCycles == `IM_MISS_CYCLES) begin
                    modelLineValid = 1'b1;
                    modelLineTag = lineNow;
                    pendingCycles = 0;
                end
            end
            if (!stallNow || excReq) begin
                if (excCtrl == excEntry) nextPc = `KTEXT_START;
                else if (excCtrl == excEret) nextPc = {epc, 2'b00};
                else if (expPc == HOLD_ADDR) nextPc = expPc;
                else nextPc = nextPcFromD(expCode, expPc, expPcD, rsValue, rtValue);
                // F/D holds while stalled even under an exception
                if (!stallNow) begin
                    expBdD = excReq ? 1'b0 : isControlTransfer(expCode);
                    expCode = excReq ? 32'd0 : romWord(expPc);
                    expPcD = excReq ? 32'd0 : expPc;
                    expExcD = excReq ? 5'd0 : adelCode(expPc);
                end
                expPc = nextPc;
            end
        end
    end

    // Random back-pressure and operands with JR targets chosen to fault
    always @(posedge clk) begin : stimulusDriver
        #1;
        decodeStall = (($random(seed) & 32'd3) == 32'd0);
        if (isJumpRegister(codeD)) begin
            rsValue = (pcD < `KTEXT_START) ? 32'h0000_3042 : 32'h0000_6000;
        end else begin
            rsValue = $random(seed) % 3;
        end
        rtValue = $random(seed) % 3;
    end

    task automatic waitAdelInD();
        int cycles;
        cycles = 0;
        while (excD != `EXC_ADEL) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) reportFailure("no address error reached D");
        end
    endtask

    task automatic waitForPc(input logic inD, input logic [31:0] addr);
        int cycles;
        cycles = 0;
        while ((inD ? pcD : pcF) != addr) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) reportFailure("expected PC was never reached");
        end
    endtask

    task automatic pulseException(input excCtrl_t kind, input logic [29:0] epcValue);
        logic [31:0] expected;
        expected = (kind == excEntry) ? `KTEXT_START : {epcValue, 2'b00};
        excCtrl = kind;
        epc = epcValue;
        @(posedge clk);
        #1;
        excCtrl = excNone;
        assert (pcF == expected) else reportMismatch("pcF", pcF, expected);
    endtask

    initial begin
        seed = 32'h3fa4;
        modelValid = 1'b0;
        reset = 1'b1;
        decodeStall = 1'b0;
        rsValue = 32'd0;
        rtValue = 32'd0;
        excCtrl = excNone;
        epc = 30'd0;
        for (int i = 0; i < `IM_WORDS; i++) begin
            romImage[i] = 32'd0;
        end
        $readmemh("tests/program.hex", romImage);

        repeat (8) @(posedge clk);
        #1;
        assert (pcF == `PC_BOOT && codeD == 32'd0 && pcD == 32'd0 && !bdD && excD == 5'd0)
            else reportFailure("state after reset is not the boot state");
        reset = 1'b0;

        // Program runs its branches and jumps and ends in a JR to a misaligned word
        waitAdelInD();
        pulseException(excEntry, 30'd0);

        // Kernel code does a JR out of the fetch window
        waitForPc(1'b1, `KTEXT_START);
        waitAdelInD();
        pulseException(excEret, 30'h105C);

        // Sequential fetch runs into the word before the kernel and parks
        waitForPc(1'b0, HOLD_ADDR);
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (pcF == HOLD_ADDR) else reportMismatch("pcF", pcF, HOLD_ADDR);
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- verilog/frontEnd.sv
/*
 * Instruction fetch front end
 * Fetch stage, decode redirect, instruction memory and hazard control
 */

`timescale 1ns/100ps

module frontEnd
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] rsValue,
    input  logic [31:0] rtValue,
    input  logic        decodeStall,
    input  excCtrl_t    excCtrl,
    input  logic [29:0] epc,
    output logic [31:0] pcF,
    output logic        bdF,
    output logic [4:0]  excF,
    output instrWord_t  codeD,
    output logic [31:0] pcD,
    output logic        bdD,
    output logic [4:0]  excD,
    output logic        busy
);

    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic        imemReady;
    logic        redirect;
    logic [31:0] target;
    logic        inBranchSlot;
    logic        stall;
    logic        clear;
    logic        pcEnable;

    fetchStage fetch (
        .clk(clk), .reset(reset),
        .redirect(redirect), .target(target), .inBranchSlot(inBranchSlot),
        .excCtrl(excCtrl), .epc(epc),
        .imemData(imemData), .imemReady(imemReady),
        .stall(stall), .clear(clear), .pcEnable(pcEnable),
        .imemAddr(imemAddr), .busy(busy),
        .pcF(pcF), .bdF(bdF), .excF(excF),
        .codeD(codeD), .pcD(pcD), .bdD(bdD), .excD(excD)
    );

    branchDecode decode (
        .codeD(codeD), .pcD(pcD),
        .rsValue(rsValue), .rtValue(rtValue),
        .redirect(redirect), .target(target), .inBranchSlot(inBranchSlot)
    );

    instrMemory imem (
        .clk(clk), .reset(reset),
        .imemAddr(imemAddr),
        .imemData(imemData), .imemReady(imemReady)
    );

    hazardControl hazard (
        .busy(busy), .decodeStall(decodeStall), .excCtrl(excCtrl),
        .stall(stall), .clear(clear), .pcEnable(pcEnable)
    );

endmodule

//--- verilog/hazardControl.sv
/*
 * Hazard controller
 * Combines memory busy, downstream stall and exception requests
 * into stall, clear and PC enable for the fetch stage
 */

`timescale 1ns/100ps

module hazardControl
    import fetchPkg::*;
(
    input  logic     busy,
    input  logic     decodeStall,
    input  excCtrl_t excCtrl,
    output logic     stall,
    output logic     clear,
    output logic     pcEnable
);

    logic excRequest;

    assign excRequest = (excCtrl != excNone);

    // Either a line miss or the later stages hold the pipe
    assign stall = busy | decodeStall;

    // Exception flushes the fetched instruction
    assign clear = excRequest;

    // Exceptions override back-pressure on the PC
    assign pcEnable = ~stall | excRequest;

endmodule

//--- verilog/instrMemory.sv
/*
 * Instruction memory
 * Hex loaded ROM behind a single 4-word line buffer, a miss costs
 * a fixed number of cycles before the line fills
 */

`timescale 1ns/100ps
`include "fetch_defs.svh"

module instrMemory (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] imemAddr,
    output logic [31:0] imemData,
    output logic        imemReady
);

    localparam int CNT_W = $clog2(`IM_MISS_CYCLES + 1);

    logic [31:0]      rom [0:`IM_WORDS-1];
    logic [31:0]      lineData [0:3];
    logic [27:0]      lineTag;
    logic             lineValid;
    logic [27:0]      missTag;
    logic [CNT_W-1:0] missCount;
    logic [31:0]      offset;
    logic             addrInRange;
    logic             hit;
    logic             continuing;
    logic             lastCycle;

    initial begin
        $readmemh("tests/program.hex", rom);
    end

    assign offset      = imemAddr - `IM_ADDR_START;
    assign addrInRange = (imemAddr >= `IM_ADDR_START) && (imemAddr < `IM_ADDR_END);

    assign hit       = lineValid && (lineTag == imemAddr[31:4]);
    assign imemReady = hit;
    assign imemData  = lineData[imemAddr[3:2]];

    // A changed address abandons the pending miss and starts over
    assign continuing = (missCount != '0) && (missTag == imemAddr[31:4]);
    assign lastCycle  = continuing ? (missCount == CNT_W'(`IM_MISS_CYCLES - 1))
                                   : (`IM_MISS_CYCLES == 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            lineValid <= 1'b0;
            missCount <= '0;
        end else if (hit) begin
            missCount <= '0;
        end else if (lastCycle) begin
            lineValid <= 1'b1;
            missCount <= '0;
        end else begin
            missCount <= continuing ? missCount + 1'b1 : CNT_W'(1);
        end
    end

    // Line fill, out-of-range lines read as zero
    always_ff @(posedge clk) begin
        if (!hit) begin
            missTag <= imemAddr[31:4];
        end
        if (!hit && lastCycle) begin
            lineTag <= imemAddr[31:4];
            for (int k = 0; k < 4; k++) begin
                lineData[k] <= addrInRange ? rom[{offset[12:4], k[1:0]}] : 32'd0;
            end
        end
    end

endmodule

//--- verilog/branchDecode.sv
/*
 * Decode redirect unit
 * Resolves the branch or jump held in D into a redirect and its target
 */

`timescale 1ns/100ps

module branchDecode
    import fetchPkg::*;
(
    input  instrWord_t  codeD,
    input  logic [31:0] pcD,
    input  logic [31:0] rsValue,
    input  logic [31:0] rtValue,
    output logic        redirect,
    output logic [31:0] target,
    output logic        inBranchSlot
);

    // Funct codes under the SPECIAL opcode
    localparam logic [5:0] FUNCT_JR   = 6'h08;
    localparam logic [5:0] FUNCT_JALR = 6'h09;

    logic [5:0]  funct;
    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        isBranch;
    logic        isJump;
    logic        taken;

    assign funct   = codeD.iView.imm16[5:0];
    assign pcPlus4 = pcD + 32'd4;

    assign branchOffset = {{14{codeD.iView.imm16[15]}}, codeD.iView.imm16, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // Region bits come from the delay slot address
    assign jumpTarget = {pcPlus4[31:28], codeD.jView.target, 2'b00};

    always_comb begin
        isBranch = 1'b0;
        isJump   = 1'b0;
        taken    = 1'b0;
        target   = branchTarget;
        case (codeD.iView.opcode)
            opSpecial: begin
                if (funct == FUNCT_JR || funct == FUNCT_JALR) begin
                    isJump = 1'b1;
                    target = rsValue;
                end
            end
            opJ, opJal: begin
                isJump = 1'b1;
                target = jumpTarget;
            end
            opBeq: begin
                isBranch = 1'b1;
                taken    = (rsValue == rtValue);
            end
            opBne: begin
                isBranch = 1'b1;
                taken    = (rsValue != rtValue);
            end
            opBlez: begin
                isBranch = 1'b1;
                taken    = ($signed(rsValue) <= $signed(32'd0));
            end
            opBgtz: begin
                isBranch = 1'b1;
                taken    = ($signed(rsValue) > $signed(32'd0));
            end
            default: begin
                isBranch = 1'b0;
            end
        endcase
    end

    assign redirect = isJump | (isBranch & taken);

    // Delay slot applies whether or not the branch is taken
    assign inBranchSlot = isJump | isBranch;

endmodule

//--- verilog/fetchStage.sv
/*
 * Fetch stage
 * Drives the instruction address, flags delay slots and AdEL,
 * and holds the F/D pipeline register
 */

`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetchStage
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  logic [31:0] target,
    input  logic        inBranchSlot,
    input  excCtrl_t    excCtrl,
    input  logic [29:0] epc,
    input  logic [31:0] imemData,
    input  logic        imemReady,
    input  logic        stall,
    input  logic        clear,
    input  logic        pcEnable,
    output logic [31:0] imemAddr,
    output logic        busy,
    output logic [31:0] pcF,
    output logic        bdF,
    output logic [4:0]  excF,
    output instrWord_t  codeD,
    output logic [31:0] pcD,
    output logic        bdD,
    output logic [4:0]  excD
);

    logic pcInRange;

    programCounter pcReg (
        .clk      (clk),
        .reset    (reset),
        .pcEnable (pcEnable),
        .redirect (redirect),
        .target   (target),
        .excCtrl  (excCtrl),
        .epc      (epc),
        .pc       (pcF)
    );

    assign imemAddr = pcF;
    assign busy     = ~imemReady;

    // Whatever D holds is a branch or jump, so this fetch is its delay slot
    assign bdF = inBranchSlot;

    assign pcInRange = (pcF >= `IM_ADDR_START) && (pcF < `IM_ADDR_END);
    assign excF = (!pcInRange || pcF[1:0] != 2'b00) ? `EXC_ADEL : 5'd0;

    // F/D register, clear turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            codeD <= '0;
            pcD   <= 32'd0;
            bdD   <= 1'b0;
            excD  <= 5'd0;
        end else if (!stall) begin
            if (clear) begin
                codeD <= '0;
                pcD   <= 32'd0;
                bdD   <= 1'b0;
                excD  <= 5'd0;
            end else begin
                codeD <= imemData;
                pcD   <= pcF;
                bdD   <= bdF;
                excD  <= excF;
            end
        end
    end

endmodule

//--- verilog/programCounter.sv
/*
 * Program counter
 * Picks the next PC from exception entry, eret, termination hold,
 * decode redirect or sequential fetch, and registers it when enabled
 */

`timescale 1ns/100ps
`include "fetch_defs.svh"

module programCounter
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pcEnable,
    input  logic        redirect,
    input  logic [31:0] target,
    input  excCtrl_t    excCtrl,
    input  logic [29:0] epc,
    output logic [31:0] pc
);

    localparam logic [31:0] HOLD_ADDR = `KTEXT_START - 32'd4;

    logic        terminated;
    logic [31:0] seqPc;
    logic [31:0] pcNext;

    // Runaway program parks on the word before the kernel entry
    assign terminated = (pc == HOLD_ADDR);

    assign seqPc = pc + 32'd4;

    // Fixed priority, exceptions first
    always_comb begin
        if (excCtrl == excEntry) begin
            pcNext = `KTEXT_START;
        end else if (excCtrl == excEret) begin
            pcNext = {epc, 2'b00};
        end else if (terminated) begin
            pcNext = pc;
        end else if (redirect) begin
            // D holds the branch, so F already holds the delay slot
            pcNext = target;
        end else begin
            pcNext = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `PC_BOOT;
        end else if (pcEnable) begin
            pc <= pcNext;
        end
    end

endmodule

//--- verilog/fetchPkg.sv
/*
 * Fetch front end types
 * Instruction word views, exception control and the opcodes seen in decode
 */

package fetchPkg;

    // Only the opcodes the redirect logic cares about
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07
    } opcode_t;

    // Exception request from CP0
    typedef enum logic [1:0] {
        excNone  = 2'd0,
        excEntry = 2'd1,
        excEret  = 2'd2
    } excCtrl_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } jFields_t;

    // Same fetched word, read as I-type or J-type
    typedef union packed {
        iFields_t iView;
        jFields_t jView;
    } instrWord_t;

endpackage

//--- verilog/fetch_defs.svh
/*
 * Fetch front end address map and timing constants
 * Boot and exception entry addresses, instruction memory range and latency
 */

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Reset PC and exception entry
`define PC_BOOT         32'h0000_3000
`define KTEXT_START     32'h0000_4180

// Legal instruction fetch window, end is exclusive
`define IM_ADDR_START   32'h0000_3000
`define IM_ADDR_END     32'h0000_5000

// ROM depth in words and line miss penalty in cycles
`define IM_WORDS        2048
`define IM_MISS_CYCLES  3

// Address error on instruction load
`define EXC_ADEL        5'd4

`endif
